// ==== logic/aluUnit.sv ====
////////////////////
// ALU for adder, logic and shift classes
// One registered result per cycle
////////////////////

module aluUnit (
    input  logic            clk,
    input  isaPkg::unitInT  aluIn_i,
    output busPkg::unitResT res_o
);

    import isaPkg::*;

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [4:0]      shamt;                     // Shift amount
    logic [XLEN-1:0] aluVal;
    logic            isAluOp;

    assign opA   = aluIn_i.opA;
    assign opB   = aluIn_i.opB;
    assign shamt = opB[4:0];                    // Low 5 bits only

    always_comb begin
        aluVal  = '0;
        isAluOp = 1'b1;
        case (aluIn_i.op)
            ADD:  aluVal = opA + opB;
            SUB:  aluVal = opA - opB;
            SLT:  aluVal = XLEN'($signed(opA) < $signed(opB));
            SLTU: aluVal = XLEN'(opA < opB);
            XOR:  aluVal = opA ^ opB;
            OR:   aluVal = opA | opB;
            AND:  aluVal = opA & opB;
            SLL:  aluVal = opA << shamt;
            SRL:  aluVal = opA >> shamt;
            SRA:  aluVal = $signed(opA) >>> shamt;  // Keeps the sign bit
            default: begin
                isAluOp = 1'b0;                 // NOP writes nothing
            end
        endcase
    end

    //////////////////// Result register
    always_ff @(posedge clk) begin
        res_o <= '{res0: aluVal, res1: '0, jump: 1'b0, we: isAluOp, wstrb: '0};
    end

endmodule

// ==== logic/branchUnit.sv ====
////////////////////
// Branch unit
// Condition, target address and link value
////////////////////

module branchUnit (
    input  logic            clk,
    input  isaPkg::unitInT  brIn_i,
    output busPkg::unitResT res_o
);

    import isaPkg::*;

    logic            isEq;
    logic            ltSigned;
    logic            ltUnsigned;
    logic            cond;                      // Taken
    logic            isLink;                    // JAL or JALR
    logic [XLEN-1:0] jalrSum;
    logic [XLEN-1:0] target;

    assign isEq       = brIn_i.opA == brIn_i.opB;
    assign ltSigned   = $signed(brIn_i.opA) < $signed(brIn_i.opB);
    assign ltUnsigned = brIn_i.opA < brIn_i.opB;

    always_comb begin
        cond   = 1'b0;
        isLink = 1'b0;
        case (brIn_i.op)
            BEQ:  cond = isEq;
            BNE:  cond = !isEq;
            BLT:  cond = ltSigned;
            BGE:  cond = !ltSigned;
            BLTU: cond = ltUnsigned;
            BGEU: cond = !ltUnsigned;
            JAL, JALR: begin
                cond   = 1'b1;                  // Always taken
                isLink = 1'b1;
            end
            default: cond = 1'b0;
        endcase
    end

    // JALR clears bit 0, the rest are PC relative
    assign jalrSum = brIn_i.opA + brIn_i.opC;
    assign target  = (brIn_i.op == JALR) ? {jalrSum[XLEN-1:1], 1'b0}
                                         : (brIn_i.npc - XLEN'(4)) + brIn_i.opC;

    always_ff @(posedge clk) begin
        res_o <= '{res0: brIn_i.npc, res1: target, jump: cond, we: isLink, wstrb: '0};
    end

endmodule

// ==== logic/busPkg.sv ====
////////////////////
// Records leaving the execute stage
// Load request, unit results and the write-back record
////////////////////

package busPkg;

    typedef struct packed {
        logic                     read;         // Load strobe
        logic [isaPkg::XLEN-1:0]  addr;         // Word aligned
    } memReqT;

    typedef struct packed {
        logic [isaPkg::XLEN-1:0]  res0;         // Result or store data
        logic [isaPkg::XLEN-1:0]  res1;         // Target or store address
        logic                     jump;         // Branch taken
        logic                     we;           // Register file write
        logic [3:0]               wstrb;        // Byte write mask
    } unitResT;

    typedef struct packed {
        logic                     valid;
        logic [isaPkg::TAG_W-1:0] tag;
        logic [isaPkg::XLEN-1:0]  res0;
        logic [isaPkg::XLEN-1:0]  res1;
        logic                     jump;
        logic                     we;
        logic [3:0]               wstrb;
    } wbT;

endpackage

// ==== logic/execDispatch.sv ====
////////////////////
// Execute stage dispatcher
// Registers the issue record and feeds only the selected unit
////////////////////

module execDispatch (
    input  logic           clk,
    input  logic           rst_i,
    input  isaPkg::issueT  issue_i,
    output isaPkg::unitInT aluIn_o,
    output isaPkg::unitInT brIn_o,
    output isaPkg::unitInT memIn_o,
    output isaPkg::unitInT bypIn_o,
    output isaPkg::ctrlT   ctrl_o
);

    import isaPkg::*;

    issueT  issueQ;                             // Cycle 1 copy of the issue record
    unitInT selIn;
    unitInT idleIn;

    stageReg #(.payloadT(issueT)) issueReg0 (
        .clk  (clk),
        .rst_i(rst_i),
        .d_i  (issue_i),
        .q_o  (issueQ)
    );

    assign selIn  = '{op: issueQ.op, opA: issueQ.opA, opB: issueQ.opB,
                      opC: issueQ.opC, npc: issueQ.npc};
    assign idleIn = '{op: NOP, opA: '0, opB: '0, opC: '0, npc: '0};

    //////////////////// Unit routing
    always_comb begin
        aluIn_o = idleIn;                       // Everyone idles by default
        brIn_o  = idleIn;
        memIn_o = idleIn;
        bypIn_o = idleIn;
        if (issueQ.valid) begin                 // Bubble keeps all units on NOP
            unique case (issueQ.xu)
                XU_ALU:    aluIn_o = selIn;
                XU_BRANCH: brIn_o  = selIn;
                XU_MEM:    memIn_o = selIn;
                XU_BYPASS: bypIn_o = selIn;
            endcase
        end
    end

    // Control that follows the instruction to the collector
    assign ctrl_o = '{valid: issueQ.valid, xu: issueQ.xu, tag: issueQ.tag};

endmodule

// ==== logic/execTop.sv ====
////////////////////
// Execute stage top level
// Dispatcher, units, control buffer and collector, 2 cycle latency
////////////////////

module execTop (
    input  logic                    clk,
    input  logic                    rst_i,
    input  isaPkg::issueT           issue_i,
    input  logic [isaPkg::XLEN-1:0] memData_i,
    output busPkg::memReqT          memReq_o,
    output busPkg::wbT              wb_o
);

    import isaPkg::*;
    import busPkg::*;

    unitInT aluIn;                              // Cycle 1 unit inputs
    unitInT brIn;
    unitInT memIn;
    unitInT bypIn;
    ctrlT   ctrl;                               // Cycle 1 control
    ctrlT   ctrlQ;                              // Aligned with unit results

    unitResT aluRes;
    unitResT brRes;
    unitResT memRes;
    unitResT bypRes;
    logic [XLEN-1:0] bypData;                   // Registered bypass operand

    //////////////////// Dispatch
    execDispatch dispatch0 (
        .clk    (clk),
        .rst_i  (rst_i),
        .issue_i(issue_i),
        .aluIn_o(aluIn),
        .brIn_o (brIn),
        .memIn_o(memIn),
        .bypIn_o(bypIn),
        .ctrl_o (ctrl)
    );

    //////////////////// Units
    aluUnit alu0 (.clk(clk), .aluIn_i(aluIn), .res_o(aluRes));
    branchUnit branch0 (.clk(clk), .brIn_i(brIn), .res_o(brRes));
    memAccessUnit mem0 (
        .clk      (clk),
        .memIn_i  (memIn),
        .memData_i(memData_i),
        .memReq_o (memReq_o),
        .res_o    (memRes)
    );

    // Bypass path holds opB for one cycle
    always_ff @(posedge clk) begin
        bypData <= (bypIn.op == PASS) ? bypIn.opB : '0;
    end
    assign bypRes = '{res0: bypData, res1: '0, jump: 1'b0, we: 1'b0, wstrb: '0};

    //////////////////// Control buffer and collect
    stageReg #(.payloadT(ctrlT)) ctrlBuf0 (.clk(clk), .rst_i(rst_i), .d_i(ctrl), .q_o(ctrlQ));

    resultCollect collect0 (
        .ctrl_i  (ctrlQ),
        .aluRes_i(aluRes),
        .brRes_i (brRes),
        .memRes_i(memRes),
        .bypRes_i(bypRes),
        .wb_o    (wb_o)
    );

endmodule

// ==== logic/isaPkg.sv ====
////////////////////
// ISA definitions for the execute stage
// Operations, unit selector and the records used inside the stage
////////////////////

package isaPkg;

    localparam int XLEN  = 32;                  // Data width
    localparam int TAG_W = 4;                   // Instruction tag width

    //////////////////// Operations
    typedef enum logic [4:0] {
        ADD, SUB, SLT, SLTU,                    // Adder class
        XOR, OR, AND,                           // Logic class
        SLL, SRL, SRA,                          // Shift class
        BEQ, BNE, BLT, BGE, BLTU, BGEU,         // Conditional branches
        JAL, JALR,                              // Jumps with link
        LB, LBU, LH, LHU, LW,                   // Loads
        SB, SH, SW,                             // Stores
        PASS,                                   // Bypass of opB
        NOP                                     // Idle operation
    } opE;

    typedef enum logic [1:0] {
        XU_ALU,
        XU_BRANCH,
        XU_MEM,
        XU_BYPASS
    } xuE;

    //////////////////// Records
    typedef struct packed {
        logic             valid;                // Low on a bubble
        opE               op;
        xuE               xu;                   // Target unit
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  npc;                  // PC of the next instruction
        logic [XLEN-1:0]  opA;
        logic [XLEN-1:0]  opB;
        logic [XLEN-1:0]  opC;                  // Offset or store data
    } issueT;

    typedef struct packed {
        opE              op;                    // NOP when the unit is idle
        logic [XLEN-1:0] opA;
        logic [XLEN-1:0] opB;
        logic [XLEN-1:0] opC;
        logic [XLEN-1:0] npc;
    } unitInT;

    typedef struct packed {
        logic             valid;
        xuE               xu;                   // Picks the result in the collector
        logic [TAG_W-1:0] tag;
    } ctrlT;

endpackage

// ==== logic/memAccessUnit.sv ====
////////////////////
// Memory access unit
// Address generation, load extension and store lane placement
////////////////////

module memAccessUnit (
    input  logic                    clk,
    input  isaPkg::unitInT          memIn_i,
    input  logic [isaPkg::XLEN-1:0] memData_i,
    output busPkg::memReqT          memReq_o,
    output busPkg::unitResT         res_o
);

    import isaPkg::*;

    logic [XLEN-1:0] addr;                      // Effective address
    logic [1:0]      lane;                      // Byte offset in the word
    logic [XLEN-1:0] shifted;                   // Read word moved to lane 0
    logic [XLEN-1:0] loadVal;
    logic [XLEN-1:0] storeData;
    logic [3:0]      strb;
    logic            isLoad;
    logic            isStore;

    assign addr = memIn_i.opA + memIn_i.opB;
    assign lane = addr[1:0];

    // Request goes out in the same cycle, data comes back before the edge
    assign memReq_o = '{read: isLoad, addr: {addr[XLEN-1:2], 2'b00}};

    //////////////////// Load path
    assign shifted = memData_i >> {lane, 3'b000};

    always_comb begin
        isLoad  = 1'b1;
        loadVal = '0;
        case (memIn_i.op)
            LB:  loadVal = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU: loadVal = {{(XLEN-8){1'b0}}, shifted[7:0]};
            LH:  loadVal = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU: loadVal = {{(XLEN-16){1'b0}}, shifted[15:0]};
            LW:  loadVal = memData_i;
            default: isLoad = 1'b0;
        endcase
    end

    //////////////////// Store path
    always_comb begin
        isStore   = 1'b1;
        storeData = '0;
        strb      = 4'b0000;
        case (memIn_i.op)
            SB: begin
                storeData = {{(XLEN-8){1'b0}}, memIn_i.opC[7:0]} << {lane, 3'b000};
                strb      = 4'b0001 << lane;
            end
            SH: begin
                storeData = {{(XLEN-16){1'b0}}, memIn_i.opC[15:0]} << {lane, 3'b000};
                strb      = 4'b0011 << lane;
            end
            SW: begin
                storeData = memIn_i.opC;
                strb      = 4'b1111 << lane;
            end
            default: isStore = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        res_o <= '{res0:  isStore ? storeData : loadVal,
                   res1:  isStore ? addr : '0,   // Store address for the next stage
                   jump:  1'b0,
                   we:    isLoad,
                   wstrb: strb};
    end

endmodule

// ==== logic/resultCollect.sv ====
////////////////////
// Result collector
// Picks the active unit and builds the write-back record
////////////////////

module resultCollect (
    input  isaPkg::ctrlT    ctrl_i,
    input  busPkg::unitResT aluRes_i,
    input  busPkg::unitResT brRes_i,
    input  busPkg::unitResT memRes_i,
    input  busPkg::unitResT bypRes_i,
    output busPkg::wbT      wb_o
);

    import isaPkg::*;
    import busPkg::*;

    unitResT bypRec;                            // Bypass result with write enable
    unitResT selRes;

    always_comb begin
        bypRec    = bypRes_i;
        bypRec.we = 1'b1;                       // PASS always writes back
    end

    always_comb begin
        case (ctrl_i.xu)
            XU_ALU:    selRes = aluRes_i;
            XU_BRANCH: selRes = brRes_i;
            XU_MEM:    selRes = memRes_i;
            default:   selRes = bypRec;
        endcase
    end

    // Side effects only for a valid instruction
    assign wb_o = '{valid: ctrl_i.valid,
                    tag:   ctrl_i.tag,
                    res0:  selRes.res0,
                    res1:  selRes.res1,
                    jump:  selRes.jump & ctrl_i.valid,
                    we:    selRes.we & ctrl_i.valid,
                    wstrb: selRes.wstrb & {4{ctrl_i.valid}}};

endmodule

// ==== logic/stageReg.sv ====
////////////////////
// Pipeline register for any packed payload
// Reset clears the whole record
////////////////////

module stageReg #(
    parameter type payloadT = logic             // Record carried by the stage
) (
    input  logic    clk,
    input  logic    rst_i,
    input  payloadT d_i,
    output payloadT q_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            q_o <= '0;                          // Valid bit drops with the rest
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module execTb -o execSim
./obj_dir/execSim | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== tb.f ====
logic/isaPkg.sv
logic/busPkg.sv
logic/stageReg.sv
logic/execDispatch.sv
logic/aluUnit.sv
logic/branchUnit.sv
logic/memAccessUnit.sv
logic/resultCollect.sv
logic/execTop.sv
tb/clkGen.sv
tb/execProps.sv
tb/execTb.sv

// ==== tb/clkGen.sv ====
////////////////////
// Testbench clock and reset
// 4 unit period, reset held for 5 cycles
////////////////////

module clkGen (
    output logic clk,
    output logic rst_o
);

    localparam int HALF = 2;                    // Half of the 4 unit period

    initial begin
        clk   = 1'b0;
        rst_o = 1'b1;
        repeat (5) @(posedge clk);              // 5 reset edges
        @(negedge clk);
        rst_o = 1'b0;                           // Released on a falling edge
    end

    always #HALF clk = ~clk;

endmodule

// ==== tb/execProps.sv ====
////////////////////
// Assertions for the execute stage
// Reset state, store strobes and 2 cycle latency
////////////////////

module execProps (
    input logic           clk,
    input logic           rst_i,
    input isaPkg::issueT  issue_i,
    input busPkg::memReqT memReq_o,
    input busPkg::wbT     wb_o
);

    import isaPkg::*;

    // Nothing in flight once a reset edge has passed
    resetClear: assert property (@(posedge clk) rst_i |=> !wb_o.valid && !memReq_o.read)
        else $error("write-back valid or load strobe high after a reset cycle");

    strobeValid: assert property (@(posedge clk) disable iff (rst_i)
        (wb_o.wstrb != 4'b0000) |->
            wb_o.valid && !wb_o.we && ($past(issue_i.op, 2) inside {SB, SH, SW}))
        else $error("byte write mask set outside a valid store write-back");

    issueLatency: assert property (@(posedge clk) disable iff (rst_i)
        issue_i.valid |-> ##2 wb_o.valid)          // Fixed 2 cycle latency
        else $error("valid issue did not reach write-back two cycles later");

endmodule

bind execTop execProps props0 (
    .clk     (clk),
    .rst_i   (rst_i),
    .issue_i (issue_i),
    .memReq_o(memReq_o),
    .wb_o    (wb_o)
);

// ==== tb/execTb.sv ====
////////////////////
// Testbench for the execute stage
// Random issue stream, memory model and in-order result check
////////////////////

module execTb;

    import isaPkg::*;
    import busPkg::*;

    localparam int N_ALU  = 400;
    localparam int N_BR   = 200;
    localparam int N_LD   = 40;                 // 5 widths, 4 offsets, twice
    localparam int N_ST   = 60;                 // 3 widths, 4 offsets, 5 times
    localparam int N_PASS = 20;
    localparam int N_MIX  = 300;
    localparam int N_ALL  = 10 + N_ALU + N_BR + N_LD + N_ST + N_PASS + N_MIX + 10;

    logic            clk;
    logic            rst;
    issueT           issue;
    memReqT          memReq;
    wbT              wb;
    logic [XLEN-1:0] memData;

    wbT     expQ[$];                            // Expected records in issue order
    longint timeQ[$];                           // Issue time of each entry
    issueT  lastIssue;                          // Record the units hold this cycle
    int     errors;
    int     checked;

    clkGen clkGen0 (.clk(clk), .rst_o(rst));

    execTop dut0 (
        .clk      (clk),
        .rst_i    (rst),
        .issue_i  (issue),
        .memData_i(memData),
        .memReq_o (memReq),
        .wb_o     (wb)
    );

    //////////////////// Memory model
    function automatic logic [XLEN-1:0] memWord(input logic [XLEN-1:0] a);
        return (a * 32'h9E37_79B1) ^ {a[7:0], a[31:8]};    // Whole address mixed in
    endfunction

    assign memData = memWord(memReq.addr);      // Answers in the same cycle

    //////////////////// Reference model
    function automatic wbT refExec(input issueT rec);
        wbT              r;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] lane;                  // Word moved down to the byte offset
        logic [4:0]      sh;
        r       = '0;
        r.valid = 1'b1;
        r.tag   = rec.tag;
        sh      = rec.opB[4:0];
        addr    = rec.opA + rec.opB;
        lane    = memWord({addr[XLEN-1:2], 2'b00}) >> {addr[1:0], 3'b000};
        case (rec.op)
            ADD:  r.res0 = rec.opA + rec.opB;
            SUB:  r.res0 = rec.opA - rec.opB;
            SLT:  r.res0 = {31'b0, $signed(rec.opA) < $signed(rec.opB)};
            SLTU: r.res0 = {31'b0, rec.opA < rec.opB};
            XOR:  r.res0 = rec.opA ^ rec.opB;
            OR:   r.res0 = rec.opA | rec.opB;
            AND:  r.res0 = rec.opA & rec.opB;
            SLL:  r.res0 = rec.opA << sh;
            SRL:  r.res0 = rec.opA >> sh;
            SRA:  r.res0 = $signed(rec.opA) >>> sh;
            BEQ:  r.jump = rec.opA == rec.opB;
            BNE:  r.jump = rec.opA != rec.opB;
            BLT:  r.jump = $signed(rec.opA) < $signed(rec.opB);
            BGE:  r.jump = $signed(rec.opA) >= $signed(rec.opB);
            BLTU: r.jump = rec.opA < rec.opB;
            BGEU: r.jump = rec.opA >= rec.opB;
            JAL, JALR: r.jump = 1'b1;
            LB:   r.res0 = {{24{lane[7]}}, lane[7:0]};
            LBU:  r.res0 = {24'b0, lane[7:0]};
            LH:   r.res0 = {{16{lane[15]}}, lane[15:0]};
            LHU:  r.res0 = {16'b0, lane[15:0]};
            LW:   r.res0 = memWord({addr[XLEN-1:2], 2'b00});
            SB:   r.res0 = {24'b0, rec.opC[7:0]} << {addr[1:0], 3'b000};
            SH:   r.res0 = {16'b0, rec.opC[15:0]} << {addr[1:0], 3'b000};
            SW:   r.res0 = rec.opC;             // Word stores stay aligned
            PASS: r.res0 = rec.opB;
            default: r.res0 = '0;
        endcase
        case (rec.xu)                           // Per class fields
            XU_ALU, XU_BYPASS: r.we = 1'b1;
            XU_BRANCH: begin
                r.res0 = rec.npc;               // Link value
                r.res1 = (rec.op == JALR) ? ((rec.opA + rec.opC) & ~32'h1)
                                          : rec.npc - 4 + rec.opC;
                r.we   = rec.op inside {JAL, JALR};
            end
            default: begin
                r.we = rec.op inside {LB, LBU, LH, LHU, LW};
                if (!r.we) begin                // Store
                    r.res1  = addr;
                    r.wstrb = 4'((rec.op == SB ? 4'b0001 : rec.op == SH ? 4'b0011 : 4'b1111)
                                 << addr[1:0]);
                end
            end
        endcase
        return r;
    endfunction

    //////////////////// Checks
    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    always @(negedge clk) begin                 // Outputs settled mid cycle
        wbT     want;
        longint issuedAt;
        if (!rst) begin
            if (wb.valid && expQ.size() == 0) begin
                errors++;
                $display("valid write-back with tag %h but no instruction was pending", wb.tag);
            end else if (wb.valid) begin
                want     = expQ.pop_front();
                issuedAt = timeQ.pop_front();
                checkEq("latency", 32'($time - issuedAt), 32'd8);    // 2 clock periods
                checkEq("wb_o.tag", 32'(wb.tag), 32'(want.tag));
                checkEq("wb_o.res0", wb.res0, want.res0);
                checkEq("wb_o.res1", wb.res1, want.res1);
                checkEq("wb_o.jump", 32'(wb.jump), 32'(want.jump));
                checkEq("wb_o.we", 32'(wb.we), 32'(want.we));
                checkEq("wb_o.wstrb", 32'(wb.wstrb), 32'(want.wstrb));
                checked++;
            end else begin
                checkEq("wb_o.jump", 32'(wb.jump), 32'd0);          // Bubble is quiet
                checkEq("wb_o.we", 32'(wb.we), 32'd0);
                checkEq("wb_o.wstrb", 32'(wb.wstrb), 32'd0);
            end
        end
    end

    //////////////////// Stimulus
    function automatic opE randOp(input int lo, input int hi);
        return opE'(5'($urandom_range(hi, lo)));
    endfunction

    function automatic logic [XLEN-1:0] pickOperand();
        case ($urandom_range(0, 7))             // Sign boundaries now and then
            0: return 32'h0000_0000;
            1: return 32'h7FFF_FFFF;
            2: return 32'h8000_0000;
            3: return 32'hFFFF_FFFF;
            default: return $urandom;
        endcase
    endfunction

    function automatic issueT mkIssue(input opE op, input xuE xu, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b, input logic [XLEN-1:0] c);
        issueT rec;
        rec.valid = 1'b1;
        rec.op    = op;
        rec.xu    = xu;
        rec.tag   = TAG_W'($urandom);
        rec.npc   = $urandom & 32'hFFFF_FFFC;   // Word aligned PC
        rec.opA   = a;
        rec.opB   = b;
        rec.opC   = c;
        return rec;
    endfunction

    task automatic drive(input issueT rec);
        logic            isLd;
        logic [XLEN-1:0] ldAddr;
        @(negedge clk);
        isLd   = lastIssue.valid && lastIssue.xu == XU_MEM
                 && lastIssue.op inside {LB, LBU, LH, LHU, LW};
        ldAddr = lastIssue.opA + lastIssue.opB;
        checkEq("memReq_o.read", 32'(memReq.read), 32'(isLd));
        if (isLd) begin
            checkEq("memReq_o.addr", memReq.addr, {ldAddr[XLEN-1:2], 2'b00});
        end
        issue     = rec;
        lastIssue = rec;
        if (rec.valid) begin
            expQ.push_back(refExec(rec));
            timeQ.push_back($time);
        end
    endtask

    task automatic issueMem(input opE op, input int off);
        logic [XLEN-1:0] base;
        base = $urandom & 32'hFFFF_FFFC;
        drive(mkIssue(op, XU_MEM, base, ($urandom & 32'h0000_0FFC) | off, $urandom));
    endtask

    task automatic issueBranch();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = pickOperand();
        b = ($urandom_range(0, 3) == 0) ? a : pickOperand();   // Equal operands too
        drive(mkIssue(randOp(int'(BEQ), int'(JALR)), XU_BRANCH, a, b, $urandom));
    endtask

    task automatic issueAlu();
        drive(mkIssue(randOp(int'(ADD), int'(SRA)), XU_ALU, pickOperand(), pickOperand(), 0));
    endtask

    task automatic issuePass();
        drive(mkIssue(PASS, XU_BYPASS, pickOperand(), pickOperand(), $urandom));
    endtask

    initial begin
        opE op;
        void'($urandom(28));
        issue     = mkIssue(LW, XU_MEM, 32'h0000_0100, 32'h0, 32'h0);  // Load held in reset
        lastIssue = '0;
        errors    = 0;
        checked   = 0;
        wait (!rst);
        issue = '0;                             // Reset must have swallowed the load
        repeat (10) drive('0);                  // Idle after reset
        repeat (N_ALU) issueAlu();
        repeat (N_BR) issueBranch();
        for (int w = int'(LB); w <= int'(LW); w++) begin
            for (int off = 0; off < 4; off++) begin
                repeat (2) issueMem(opE'(5'(w)), off);
            end
        end
        for (int w = int'(SB); w <= int'(SW); w++) begin
            for (int off = 0; off < 4; off++) begin
                repeat (5) issueMem(opE'(5'(w)), (w == int'(SW)) ? 0 : off);
            end
        end
        repeat (N_PASS) issuePass();
        repeat (N_MIX) begin                    // Mixed stream with bubbles
            case ($urandom_range(0, 5))
                0: issueAlu();
                1: issueBranch();
                2: begin
                    op = randOp(int'(LB), int'(SW));
                    issueMem(op, (op == SW) ? 0 : int'($urandom_range(0, 3)));
                end
                3: issuePass();
                default: drive('0);
            endcase
        end
        repeat (10) drive('0);                  // Drain the pipeline
        if (expQ.size() != 0) begin
            errors++;
            $display("%0d issued instructions never reached write-back", expQ.size());
        end
        $display("Checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    //////////////////// Watchdog
    initial begin
        #((N_ALL + 5 + 50) * 4);                // Every drive plus reset and slack
        $display("Watchdog expired before the test sequence completed");
        $display("Done: errors found");
        $finish;
    end

endmodule
